//--- sources.f
+incdir+verification
design/dl_lphy_pkg.sv
design/dl_fh_router.sv
design/frm_mrkr_align.sv
design/dl_carrier_combiner.sv
design/dl_lphy_top.sv
verification/tb_dl_lphy.sv

//--- Bender.yml
package:
  name: dl_lphy

sources:
  - files:
      - design/dl_lphy_pkg.sv
      - design/dl_fh_router.sv
      - design/frm_mrkr_align.sv
      - design/dl_carrier_combiner.sv
      - design/dl_lphy_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_dl_lphy.sv

//--- verification/dl_lphy_model.svh
`ifndef DL_LPHY_MODEL_SVH
`define DL_LPHY_MODEL_SVH

logic [SAMPLE_WIDTH-1:0] exp_q [N_CAR][N_ANT][$];   // predicted samples per carrier and antenna
int                      frm_q [N_CAR][$];          // edge index at which a frame pulse is due
int                      sym_cnt_m [N_CAR];         // beats since the last symbol start

// one half of a word after byte reversal and I/Q exchange
function automatic logic [SAMPLE_WIDTH-1:0] ref_sample(input logic [63:0] w, input bit hi);
    logic [15:0] i_c;
    logic [15:0] q_c;
    i_c = hi ? w[63:48] : w[31:16];                 // I sits above Q
    q_c = hi ? w[47:32] : w[15:0];
    if (iq_endianness) begin
        i_c = {i_c[7:0], i_c[15:8]};                // bytes flipped per component
        q_c = {q_c[7:0], q_c[15:8]};
    end
    return iq_swap ? {q_c, i_c} : {i_c, q_c};
endfunction

// accepted fronthaul word, masked or unknown carriers give nothing
function automatic void push_word(input int c, input int a, input logic [63:0] w);
    if (c < N_CAR && radio_en[c] && ant_en[c][a]) begin
        exp_q[c][a].push_back(ref_sample(w, 1'b0)); // lower sample first
        exp_q[c][a].push_back(ref_sample(w, 1'b1));
    end
endfunction

function automatic bit model_empty();
    for (int c = 0; c < N_CAR; c++) begin
        for (int a = 0; a < N_ANT; a++) begin
            if (exp_q[c][a].size() != 0) begin
                return 1'b0;
            end
        end
    end
    return 1'b1;
endfunction

`endif

//--- verification/tb_dl_lphy.sv
`timescale 1ns/1ps

module tb_dl_lphy;

    import dl_lphy_pkg::*;

    localparam int N_ANT      = 4;
    localparam int N_CAR      = 2;
    localparam int SYM        = 16;
    localparam int DLY        = 8;
    localparam int N_PHASES   = 4;                      // all iq_swap / endianness pairs
    localparam int WORDS      = 40;                     // per antenna and phase
    localparam int MAX_CYCLES = 4 * N_PHASES * N_ANT * WORDS + 2000;

    logic                        radio_if_clk;
    logic                        rst_n;
    fh_beat_s [N_ANT-1:0]        fh_in;
    logic [N_ANT-1:0]            fh_in_valid;
    logic [N_ANT-1:0]            fh_in_ready;
    dfe_beat_s [N_CAR-1:0]       dfe_out;
    logic [N_CAR-1:0]            dfe_out_valid;
    logic [N_CAR-1:0]            dfe_out_ready;
    logic [N_CAR-1:0][N_ANT-1:0] ant_en;
    logic [N_CAR-1:0]            radio_en;
    logic                        iq_swap;
    logic                        iq_endianness;
    logic [N_CAR-1:0]            dl_frm_mrkr_10ms;
    logic [N_CAR-1:0]            dl_dfe_frm_mrkr;

    int                    errors;
    int                    beats;                       // dfe beats checked
    int                    cyc;                         // edges since start
    int                    words_left [N_ANT];
    int                    mrk_wait [N_CAR];            // cycles to the next marker change
    logic [N_ANT-1:0]      acc;                         // beat taken at the coming edge
    logic                  ready_on;                    // router ready expected up
    logic [N_CAR-1:0]      prev_stall;
    dfe_beat_s [N_CAR-1:0] prev_out;

    `include "dl_lphy_model.svh"

    dl_lphy_top #(
        .N_ANTENNAS     (N_ANT),
        .N_CARRIERS     (N_CAR),
        .SYMBOL_SAMPLES (SYM),
        .FRM_DLY        (DLY)
    ) u_dut (
        .radio_if_clk     (radio_if_clk),
        .rst_n            (rst_n),
        .fh_in            (fh_in),
        .fh_in_valid      (fh_in_valid),
        .fh_in_ready      (fh_in_ready),
        .dfe_out          (dfe_out),
        .dfe_out_valid    (dfe_out_valid),
        .dfe_out_ready    (dfe_out_ready),
        .ant_en           (ant_en),
        .radio_en         (radio_en),
        .iq_swap          (iq_swap),
        .iq_endianness    (iq_endianness),
        .dl_frm_mrkr_10ms (dl_frm_mrkr_10ms),
        .dl_dfe_frm_mrkr  (dl_dfe_frm_mrkr)
    );

    always #20 radio_if_clk = ~radio_if_clk;

    always @(posedge radio_if_clk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            $display("run did not finish within %0d cycles, %0d errors", MAX_CYCLES, errors);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // fronthaul words, dfe ready and frame markers
    always @(posedge radio_if_clk) begin
        if (rst_n) begin
            for (int a = 0; a < N_ANT; a++) begin
                if (!fh_in_valid[a] || acc[a]) begin
                    if (words_left[a] > 0 && $urandom_range(3) != 0) begin
                        fh_in[a]       <= {$urandom, $urandom, CAR_ID_W'($urandom)};
                        fh_in_valid[a] <= 1'b1;
                        words_left[a]  <= words_left[a] - 1;
                    end else begin
                        fh_in_valid[a] <= 1'b0;         // random gap
                    end
                end
            end
            for (int c = 0; c < N_CAR; c++) begin
                dfe_out_ready[c] <= ($urandom_range(3) != 0);
                if (mrk_wait[c] > 0) begin
                    mrk_wait[c] <= mrk_wait[c] - 1;
                end else if (dl_frm_mrkr_10ms[c]) begin
                    dl_frm_mrkr_10ms[c] <= 1'b0;
                    mrk_wait[c]         <= $urandom_range(90, 30);
                end else begin
                    dl_frm_mrkr_10ms[c] <= 1'b1;
                    mrk_wait[c]         <= 2;
                    frm_q[c].push_back(cyc + DLY + 3);  // sampled next edge, then 1 + DLY
                end
            end
        end
    end

    task automatic check_dfe_beat(input int c, input logic pulse);
        int                      a;
        int                      eff;
        logic [SAMPLE_WIDTH-1:0] exp_s;
        a   = dfe_out[c].ant_id;
        eff = pulse ? 0 : sym_cnt_m[c];                 // frame pulse restarts the count
        beats++;
        assert (dfe_out[c].sym_mrkr == (eff == 0)) else begin
            errors++;
            $display("FAIL sym_mrkr car %0d: expected %0b, actual %0b",
                     c, eff == 0, dfe_out[c].sym_mrkr);
        end
        sym_cnt_m[c] = (eff == SYM - 1) ? 0 : eff + 1;
        assert (exp_q[c][a].size() > 0) else begin
            errors++;
            $display("carrier %0d sent a beat for antenna %0d with no word pending", c, a);
        end
        if (exp_q[c][a].size() > 0) begin
            exp_s = exp_q[c][a].pop_front();
            assert (dfe_out[c].sample == exp_s) else begin
                errors++;
                $display("FAIL sample car %0d ant %0d: expected %h, actual %h",
                         c, a, exp_s, dfe_out[c].sample);
            end
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge radio_if_clk) begin
        logic pulse;
        if (!rst_n) begin
            acc      = '0;
            ready_on = 1'b0;
        end else begin
            // ready comes up one cycle after reset, unknown carrier ids never stall
            for (int a = 0; a < N_ANT; a++) begin
                if (!ready_on || fh_in[a].car_id >= N_CAR) begin
                    assert (fh_in_ready[a] == ready_on) else begin
                        errors++;
                        $display("FAIL fh_in_ready ant %0d: expected %0b, actual %0b",
                                 a, ready_on, fh_in_ready[a]);
                    end
                end
            end
            ready_on = 1'b1;
            acc = fh_in_valid & fh_in_ready;
            for (int a = 0; a < N_ANT; a++) begin
                if (acc[a]) begin
                    push_word(int'(fh_in[a].car_id), a, fh_in[a].data);
                end
            end
            for (int c = 0; c < N_CAR; c++) begin
                pulse = frm_q[c].size() > 0 && frm_q[c][0] == cyc;
                if (pulse) begin
                    void'(frm_q[c].pop_front());
                end
                assert (dl_dfe_frm_mrkr[c] == pulse) else begin
                    errors++;
                    $display("FAIL frame_marker car %0d: expected %0b, actual %0b",
                             c, pulse, dl_dfe_frm_mrkr[c]);
                end
                if (prev_stall[c]) begin
                    assert (dfe_out_valid[c] && dfe_out[c].sample == prev_out[c].sample
                            && dfe_out[c].ant_id == prev_out[c].ant_id) else begin
                        errors++;
                        $display("carrier %0d changed or dropped its beat while stalled", c);
                    end
                end
                if (dfe_out_valid[c] && dfe_out_ready[c]) begin
                    check_dfe_beat(c, pulse);
                end else if (pulse) begin
                    sym_cnt_m[c] = 0;
                end
                prev_stall[c] = dfe_out_valid[c] && !dfe_out_ready[c];
                prev_out[c]   = dfe_out[c];
            end
        end
    end

    function automatic bit stim_done();
        for (int a = 0; a < N_ANT; a++) begin
            if (words_left[a] != 0) begin
                return 1'b0;
            end
        end
        return fh_in_valid == '0;
    endfunction

    // new controls only while the datapath is empty
    task automatic run_phase(input int ph);
        @(posedge radio_if_clk);
        iq_swap       <= ph[0];
        iq_endianness <= ph[1];
        ant_en        <= (ph == 0) ? '1 : (N_CAR * N_ANT)'($urandom);
        radio_en      <= (ph == 2) ? 2'b01 : 2'b11;     // carrier 1 off once
        for (int a = 0; a < N_ANT; a++) begin
            words_left[a] <= WORDS;
        end
        @(posedge radio_if_clk);
        do @(negedge radio_if_clk); while (!stim_done() || !model_empty());
        repeat (3 * N_ANT) @(negedge radio_if_clk);     // masked words flushed
    endtask

    initial begin
        void'($urandom(79));
        radio_if_clk     = 1'b0;
        rst_n            = 1'b0;
        fh_in            = '0;
        fh_in_valid      = '0;
        dfe_out_ready    = '0;
        ant_en           = '1;
        radio_en         = '1;
        iq_swap          = 1'b0;
        iq_endianness    = 1'b0;
        dl_frm_mrkr_10ms = '0;
        errors           = 0;
        beats            = 0;
        cyc              = 0;
        acc              = '0;
        ready_on         = 1'b0;
        prev_stall       = '0;
        prev_out         = '0;
        for (int a = 0; a < N_ANT; a++) begin
            words_left[a] = 0;
        end
        for (int c = 0; c < N_CAR; c++) begin
            mrk_wait[c]  = $urandom_range(40, 5);
            sym_cnt_m[c] = 0;
        end
        repeat (4) @(posedge radio_if_clk);
        rst_n <= 1'b1;
        for (int ph = 0; ph < N_PHASES; ph++) begin
            run_phase(ph);
        end
        $display("checked %0d dfe beats, %0d errors", beats, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- design/dl_lphy_top.sv
`timescale 1ns/1ps

module dl_lphy_top #(
    parameter int N_ANTENNAS     = 4,
    parameter int N_CARRIERS     = 2,
    parameter int SYMBOL_SAMPLES = 16,
    parameter int FRM_DLY        = 8
) (
    input  logic                                    radio_if_clk,
    input  logic                                    rst_n,
    input  dl_lphy_pkg::fh_beat_s [N_ANTENNAS-1:0]  fh_in,             // from oran
    input  logic [N_ANTENNAS-1:0]                   fh_in_valid,
    output logic [N_ANTENNAS-1:0]                   fh_in_ready,
    output dl_lphy_pkg::dfe_beat_s [N_CARRIERS-1:0] dfe_out,           // to dfe
    output logic [N_CARRIERS-1:0]                   dfe_out_valid,
    input  logic [N_CARRIERS-1:0]                   dfe_out_ready,
    input  logic [N_CARRIERS-1:0][N_ANTENNAS-1:0]   ant_en,            // stream enables
    input  logic [N_CARRIERS-1:0]                   radio_en,          // carrier enable
    input  logic                                    iq_swap,
    input  logic                                    iq_endianness,
    input  logic [N_CARRIERS-1:0]                   dl_frm_mrkr_10ms,
    output logic [N_CARRIERS-1:0]                   dl_dfe_frm_mrkr
);

    import dl_lphy_pkg::*;

    fh_word_u [N_CARRIERS-1:0][N_ANTENNAS-1:0]  slot_beat;   // car x ant words
    logic [N_CARRIERS-1:0][N_ANTENNAS-1:0]      slot_valid;
    logic [N_CARRIERS-1:0][N_ANTENNAS-1:0]      slot_take;

    dl_fh_router #(
        .N_ANTENNAS (N_ANTENNAS),
        .N_CARRIERS (N_CARRIERS)
    ) u_dl_fh_router (
        .radio_if_clk (radio_if_clk),
        .rst_n        (rst_n),
        .fh_in        (fh_in),
        .fh_in_valid  (fh_in_valid),
        .fh_in_ready  (fh_in_ready),
        .slot_beat    (slot_beat),
        .slot_valid   (slot_valid),
        .slot_take    (slot_take)
    );

    for (genvar c = 0; c < N_CARRIERS; c++) begin : g_car
        frm_mrkr_align #(
            .FRM_DLY (FRM_DLY)
        ) u_frm_mrkr_align (
            .radio_if_clk  (radio_if_clk),
            .rst_n         (rst_n),
            .frm_mrkr_10ms (dl_frm_mrkr_10ms[c]),
            .frm_pulse     (dl_dfe_frm_mrkr[c])       // also restarts symbols
        );

        dl_carrier_combiner #(
            .N_ANTENNAS     (N_ANTENNAS),
            .SYMBOL_SAMPLES (SYMBOL_SAMPLES)
        ) u_dl_carrier_combiner (
            .radio_if_clk  (radio_if_clk),
            .rst_n         (rst_n),
            .ant_en        (ant_en[c]),
            .radio_en      (radio_en[c]),
            .iq_swap       (iq_swap),
            .iq_endianness (iq_endianness),
            .frm_pulse     (dl_dfe_frm_mrkr[c]),
            .slot_beat     (slot_beat[c]),
            .slot_valid    (slot_valid[c]),
            .slot_take     (slot_take[c]),
            .dfe_out       (dfe_out[c]),
            .dfe_out_valid (dfe_out_valid[c]),
            .dfe_out_ready (dfe_out_ready[c])
        );
    end

endmodule

//--- design/dl_carrier_combiner.sv
`timescale 1ns/1ps

module dl_carrier_combiner #(
    parameter int N_ANTENNAS     = 4,
    parameter int SYMBOL_SAMPLES = 16
) (
    input  logic                                    radio_if_clk,
    input  logic                                    rst_n,
    input  logic [N_ANTENNAS-1:0]                   ant_en,
    input  logic                                    radio_en,
    input  logic                                    iq_swap,
    input  logic                                    iq_endianness,
    input  logic                                    frm_pulse,     // restarts symbol count
    input  dl_lphy_pkg::fh_word_u [N_ANTENNAS-1:0]  slot_beat,
    input  logic [N_ANTENNAS-1:0]                   slot_valid,
    output logic [N_ANTENNAS-1:0]                   slot_take,
    output dl_lphy_pkg::dfe_beat_s                  dfe_out,
    output logic                                    dfe_out_valid,
    input  logic                                    dfe_out_ready
);

    import dl_lphy_pkg::*;

    localparam int CNT_W = (SYMBOL_SAMPLES > 1) ? $clog2(SYMBOL_SAMPLES) : 1;

    logic                     busy;        // a word is being sent
    logic                     half;        // upper sample on the output
    logic [ANT_ID_W-1:0]      cur_ant;     // antenna being sent
    logic [ANT_ID_W-1:0]      rr_ptr;      // first antenna to look at
    logic [ANT_ID_W-1:0]      pick;        // arbiter choice
    logic [ANT_ID_W-1:0]      nxt_ptr;
    logic                     pick_vld;
    logic                     grant;       // start sending the picked word
    logic                     drop;        // picked word is discarded
    logic                     xfer;        // dfe beat accepted
    logic [SAMPLE_WIDTH-1:0]  out_sample;
    logic [CNT_W-1:0]         sym_cnt;     // beats since last symbol start
    logic [CNT_W-1:0]         eff_cnt;     // count of the current beat

    // byte order fix per component, then optional I/Q exchange
    function automatic logic [SAMPLE_WIDTH-1:0] fmt_sample(
        input fh_word_u w,
        input logic     hi,
        input logic     swap_iq,
        input logic     endian
    );
        fh_word_u v;
        iq_s      s;
        v = w;
        if (endian) begin
            for (int b = 0; b < FH_DATA_WIDTH / 8; b += 2) begin
                v.byte_v[b]     = w.byte_v[b + 1];       // swap inside each 16 bit half
                v.byte_v[b + 1] = w.byte_v[b];
            end
        end
        s = v.smp[hi];
        if (swap_iq) begin
            s.i = v.smp[hi].q;
            s.q = v.smp[hi].i;
        end
        return s;
    endfunction

    // round robin search starting at rr_ptr
    always_comb begin
        int unsigned idx;
        pick     = rr_ptr;
        pick_vld = 1'b0;
        for (int k = N_ANTENNAS - 1; k >= 0; k--) begin
            idx = (rr_ptr + k) % N_ANTENNAS;
            if (slot_valid[idx]) begin
                pick     = ANT_ID_W'(idx);               // lowest offset wins
                pick_vld = 1'b1;
            end
        end
    end

    assign nxt_ptr = (pick == ANT_ID_W'(N_ANTENNAS - 1)) ? '0 : pick + 1'b1;
    assign grant   = !busy && pick_vld && ant_en[pick] && radio_en;
    assign drop    = !busy && pick_vld && !(ant_en[pick] && radio_en);
    assign xfer    = dfe_out_valid && dfe_out_ready;

    always_comb begin
        slot_take = '0;
        if (drop) begin
            slot_take[pick] = 1'b1;                      // masked word is flushed
        end
        if (busy && half && xfer) begin
            slot_take[cur_ant] = 1'b1;                   // both samples gone
        end
    end

    always_ff @(posedge radio_if_clk) begin
        if (!rst_n) begin
            busy          <= 1'b0;
            half          <= 1'b0;
            cur_ant       <= '0;
            rr_ptr        <= '0;
            dfe_out_valid <= 1'b0;
        end else begin
            if (grant) begin
                busy          <= 1'b1;
                half          <= 1'b0;
                cur_ant       <= pick;
                rr_ptr        <= nxt_ptr;
                dfe_out_valid <= 1'b1;
            end else if (drop) begin
                rr_ptr <= nxt_ptr;
            end else if (busy && xfer) begin
                if (!half) begin
                    half <= 1'b1;                        // move to the upper sample
                end else begin
                    busy          <= 1'b0;
                    half          <= 1'b0;
                    dfe_out_valid <= 1'b0;
                end
            end
        end
    end

    // sample register, lower sample first
    always_ff @(posedge radio_if_clk) begin
        if (grant) begin
            out_sample <= fmt_sample(slot_beat[pick], 1'b0, iq_swap, iq_endianness);
        end else if (busy && xfer && !half) begin
            out_sample <= fmt_sample(slot_beat[cur_ant], 1'b1, iq_swap, iq_endianness);
        end
    end

    // frame pulse makes the beat of this cycle, or the next one, count zero
    assign eff_cnt = frm_pulse ? '0 : sym_cnt;

    always_ff @(posedge radio_if_clk) begin
        if (!rst_n) begin
            sym_cnt <= '0;
        end else if (xfer) begin
            sym_cnt <= (eff_cnt == CNT_W'(SYMBOL_SAMPLES - 1)) ? '0 : eff_cnt + 1'b1;
        end else if (frm_pulse) begin
            sym_cnt <= '0;
        end
    end

    assign dfe_out.sample   = out_sample;
    assign dfe_out.ant_id   = cur_ant;
    assign dfe_out.sym_mrkr = (eff_cnt == '0);

    // a stalled beat holds; only a frame pulse may raise its marker
    a_dfe_hold: assert property (
        @(posedge radio_if_clk) disable iff (!rst_n)
        dfe_out_valid && !dfe_out_ready |=> dfe_out_valid
            && $stable(dfe_out.sample) && $stable(dfe_out.ant_id)
            && (dfe_out.sym_mrkr || !$past(dfe_out.sym_mrkr))
    );

endmodule

//--- design/frm_mrkr_align.sv
`timescale 1ns/1ps

module frm_mrkr_align #(
    parameter int FRM_DLY = 8
) (
    input  logic radio_if_clk,
    input  logic rst_n,
    input  logic frm_mrkr_10ms,   // level from the timing block
    output logic frm_pulse        // delayed single-cycle pulse
);

    logic               mrkr_q;   // sampled marker
    logic               mrkr_qq;  // previous sample
    logic               rise;     // rising edge seen
    logic [FRM_DLY-1:0] dly_sr;   // delay line

    assign rise = mrkr_q && !mrkr_qq;

    always_ff @(posedge radio_if_clk) begin
        if (!rst_n) begin
            mrkr_q    <= 1'b0;
            mrkr_qq   <= 1'b0;
            dly_sr    <= '0;
            frm_pulse <= 1'b0;
        end else begin
            mrkr_q    <= frm_mrkr_10ms;
            mrkr_qq   <= mrkr_q;
            dly_sr[0] <= rise;                           // edge enters the line
            for (int i = 1; i < FRM_DLY; i++) begin
                dly_sr[i] <= dly_sr[i-1];
            end
            frm_pulse <= dly_sr[FRM_DLY-1];              // registered output
        end
    end

    // an edge needs two samples so pulses cannot touch
    a_single_pulse: assert property (
        @(posedge radio_if_clk) disable iff (!rst_n)
        frm_pulse |=> !frm_pulse
    );

endmodule

//--- design/dl_fh_router.sv
`timescale 1ns/1ps

module dl_fh_router #(
    parameter int N_ANTENNAS = 4,
    parameter int N_CARRIERS = 2
) (
    input  logic                                                    radio_if_clk,
    input  logic                                                    rst_n,
    input  dl_lphy_pkg::fh_beat_s [N_ANTENNAS-1:0]                  fh_in,       // per antenna
    input  logic [N_ANTENNAS-1:0]                                   fh_in_valid,
    output logic [N_ANTENNAS-1:0]                                   fh_in_ready,
    output dl_lphy_pkg::fh_word_u [N_CARRIERS-1:0][N_ANTENNAS-1:0]  slot_beat,   // car x ant
    output logic [N_CARRIERS-1:0][N_ANTENNAS-1:0]                   slot_valid,
    input  logic [N_CARRIERS-1:0][N_ANTENNAS-1:0]                   slot_take    // from combiners
);

    import dl_lphy_pkg::*;

    logic                                     ready_en;  // holds ready low right after reset
    logic [N_CARRIERS-1:0][N_ANTENNAS-1:0]    load;      // slot write strobes

    // decode car_id per antenna and look at the addressed slot
    always_comb begin
        load = '0;
        for (int a = 0; a < N_ANTENNAS; a++) begin
            fh_in_ready[a] = ready_en;                   // unknown carrier ids are sunk
            for (int c = 0; c < N_CARRIERS; c++) begin
                if (fh_in[a].car_id == CAR_ID_W'(c)) begin
                    // free slot or one being emptied this cycle
                    fh_in_ready[a] = ready_en && (!slot_valid[c][a] || slot_take[c][a]);
                    load[c][a]     = fh_in_valid[a] && fh_in_ready[a];
                end
            end
        end
    end

    always_ff @(posedge radio_if_clk) begin
        if (!rst_n) begin
            ready_en   <= 1'b0;
            slot_valid <= '0;
        end else begin
            ready_en <= 1'b1;                            // ready from the first cycle after reset
            for (int c = 0; c < N_CARRIERS; c++) begin
                for (int a = 0; a < N_ANTENNAS; a++) begin
                    if (load[c][a]) begin
                        slot_valid[c][a] <= 1'b1;        // refill wins over take
                    end else if (slot_take[c][a]) begin
                        slot_valid[c][a] <= 1'b0;
                    end
                end
            end
        end
    end

    // holding registers for the words
    always_ff @(posedge radio_if_clk) begin
        for (int c = 0; c < N_CARRIERS; c++) begin
            for (int a = 0; a < N_ANTENNAS; a++) begin
                if (load[c][a]) begin
                    slot_beat[c][a] <= fh_in[a].data;
                end
            end
        end
    end

    // combiner only takes what the router holds
    a_take_full: assert property (
        @(posedge radio_if_clk) disable iff (!rst_n)
        (slot_take & ~slot_valid) == '0
    );

    // fronthaul source keeps a stalled beat in place
    for (genvar a = 0; a < N_ANTENNAS; a++) begin : g_fh_stable
        a_fh_hold: assert property (
            @(posedge radio_if_clk) disable iff (!rst_n)
            fh_in_valid[a] && !fh_in_ready[a] |=> fh_in_valid[a] && $stable(fh_in[a])
        );
    end

endmodule

//--- design/dl_lphy_pkg.sv
package dl_lphy_pkg;

    localparam int FH_DATA_WIDTH = 64;                 // one fronthaul word
    localparam int PRECISION     = 16;                 // bits per I or Q
    localparam int SAMPLE_WIDTH  = 2 * PRECISION;      // one IQ pair
    localparam int MAX_CARRIERS  = 4;                  // limit of the carrier-id field
    localparam int CAR_ID_W      = $clog2(MAX_CARRIERS);
    localparam int ANT_ID_W      = 2;                  // antenna index on the dfe side

    // one IQ sample, I in the upper half
    typedef struct packed {
        logic [PRECISION-1:0] i;                       // in-phase
        logic [PRECISION-1:0] q;                       // quadrature
    } iq_s;

    // a fronthaul word seen either as samples or as raw bytes
    typedef union packed {
        iq_s [1:0]                            smp;     // [0] is the lower sample
        logic [FH_DATA_WIDTH/8-1:0][7:0]      byte_v;  // byte view for endianness swap
    } fh_word_u;

    // fronthaul beat as it arrives per antenna
    typedef struct packed {
        fh_word_u              data;                   // payload word
        logic [CAR_ID_W-1:0]   car_id;                 // from the user field
    } fh_beat_s;

    // one beat towards the dfe
    typedef struct packed {
        logic [SAMPLE_WIDTH-1:0] sample;               // reformatted IQ
        logic [ANT_ID_W-1:0]     ant_id;               // source antenna
        logic                    sym_mrkr;             // first sample of a symbol
    } dfe_beat_s;

endpackage
